/* hdl/soc_pkg.sv */
// Bus widths, bus encodings, address map, UART offsets and FSM state types
package soc_pkg;

// ----------------------------------------------------------------------
// Widths and basic types

localparam int W_ADDR  = 32;
localparam int W_DATA  = 32;
localparam int W_PADDR = 16;

typedef logic [W_ADDR-1:0]  addr_t;
typedef logic [W_DATA-1:0]  word_t;
typedef logic [W_PADDR-1:0] paddr_t;

// AHB-Lite transfer type and size encodings
typedef enum logic [1:0] {
	trans_idle   = 2'b00,
	trans_busy   = 2'b01,
	trans_nonseq = 2'b10,
	trans_seq    = 2'b11
} htrans_t;

typedef enum logic [2:0] {
	size_byte = 3'b000,
	size_half = 3'b001,
	size_word = 3'b010
} hsize_t;

// ----------------------------------------------------------------------
// Address map

// Bits 27:26 pick the region, the SDRAM hole at 0x0800_0000 is unmapped
localparam addr_t TCM_BASE    = 32'h0000_0000;
localparam addr_t PERI_BASE   = 32'h0c00_0000;
localparam addr_t REGION_MASK = 32'h0c00_0000;

// APB slots are 4 KiB each, selected by paddr[15:12]
localparam logic [3:0] APB_SLOT_UART = 4'h0;

localparam paddr_t UART_CSR    = 16'h0000;
localparam paddr_t UART_DIV    = 16'h0004;
localparam paddr_t UART_TXDATA = 16'h0008;

// ----------------------------------------------------------------------
// State machines

typedef enum logic [2:0] {
	br_idle, br_setup, br_access, br_err_first, br_done
} bridge_state_t;

typedef enum logic [1:0] {
	uart_idle, uart_start, uart_data, uart_stop
} uart_state_t;

endpackage

/* hdl/ahb_splitter.sv */
// AHB-Lite region decoder, data-phase response mux and unmapped-space error responder
`timescale 1ns/10ps

module ahb_splitter (
	input  logic             clk_sys,
	input  logic             rst_n,
	input  soc_pkg::addr_t   haddr,
	input  soc_pkg::htrans_t htrans,
	output logic             hready,
	output logic             hresp,
	output soc_pkg::word_t   hrdata,
	output logic             sram_sel,
	output logic             peri_sel,
	input  logic             sram_hready_resp,
	input  logic             sram_hresp,
	input  soc_pkg::word_t   sram_hrdata,
	input  logic             peri_hready_resp,
	input  logic             peri_hresp,
	input  soc_pkg::word_t   peri_hrdata
);
import soc_pkg::*;

// Owner of the current data phase
typedef enum logic [1:0] {
	tgt_none, tgt_sram, tgt_peri, tgt_err
} target_t;

target_t target_q;
logic    err_second_q;
logic    trans_valid;
addr_t   region;

assign region      = haddr & REGION_MASK;
assign sram_sel    = region == TCM_BASE;
assign peri_sel    = region == PERI_BASE;
assign trans_valid = htrans == trans_nonseq || htrans == trans_seq;

always_ff @(posedge clk_sys) begin
	if (!rst_n) begin
		target_q     <= tgt_none;
		err_second_q <= 1'b0;
	end else begin
		if (hready) begin
			if (!trans_valid)
				target_q <= tgt_none;
			else if (sram_sel)
				target_q <= tgt_sram;
			else if (peri_sel)
				target_q <= tgt_peri;
			else
				target_q <= tgt_err;
		end
		// Second cycle of the two-cycle local error
		err_second_q <= target_q == tgt_err && !err_second_q;
	end
end

always_comb begin
	hready = 1'b1;
	hresp  = 1'b0;
	hrdata = '0;
	case (target_q)
		tgt_sram: begin
			hready = sram_hready_resp;
			hresp  = sram_hresp;
			hrdata = sram_hrdata;
		end
		tgt_peri: begin
			hready = peri_hready_resp;
			hresp  = peri_hresp;
			hrdata = peri_hrdata;
		end
		tgt_err: begin
			hready = err_second_q;
			hresp  = 1'b1;
		end
		default: ;
	endcase
end

// Any error, local or from the bridge, completes in the following cycle
assert property (@(posedge clk_sys) disable iff (!rst_n)
	hresp && !hready |=> hresp && hready);

endmodule

/* hdl/ahb_sram.sv */
// Zero-wait-state AHB-Lite SRAM with byte lane writes
`timescale 1ns/10ps

module ahb_sram #(
	parameter int SRAM_DEPTH = 1024
) (
	input  logic             clk_sys,
	input  logic             rst_n,
	input  logic             sel,
	input  logic             hready,
	input  soc_pkg::addr_t   haddr,
	input  logic             hwrite,
	input  soc_pkg::htrans_t htrans,
	input  soc_pkg::hsize_t  hsize,
	input  soc_pkg::word_t   hwdata,
	output logic             hready_resp,
	output logic             hresp,
	output soc_pkg::word_t   hrdata
);
import soc_pkg::*;

// Depth is a power of two, so the index bits wrap the address
localparam int W_IDX = $clog2(SRAM_DEPTH);

word_t            mem [SRAM_DEPTH];
logic             addr_phase;
logic             dph_active;
logic             dph_write;
hsize_t           dph_size;
logic [W_IDX-1:0] dph_idx;
logic [1:0]       dph_lsb;
logic [3:0]       byte_en;

assign addr_phase = sel && hready && (htrans == trans_nonseq || htrans == trans_seq);

always_ff @(posedge clk_sys) begin
	if (!rst_n)
		dph_active <= 1'b0;
	else if (hready)
		dph_active <= addr_phase;
end

always_ff @(posedge clk_sys) begin
	if (addr_phase) begin
		dph_write <= hwrite;
		dph_size  <= hsize;
		dph_idx   <= haddr[W_IDX+1:2];
		dph_lsb   <= haddr[1:0];
	end
end

always_comb begin
	case (dph_size)
		size_byte: byte_en = 4'b0001 << dph_lsb;
		size_half: byte_en = 4'b0011 << {dph_lsb[1], 1'b0};
		default:   byte_en = 4'b1111;
	endcase
end

// Write lands at the end of the data phase
always_ff @(posedge clk_sys) begin
	if (dph_active && dph_write) begin
		for (int i = 0; i < 4; i++) begin
			if (byte_en[i])
				mem[dph_idx][8*i +: 8] <= hwdata[8*i +: 8];
		end
	end
end

assign hrdata      = mem[dph_idx];
assign hready_resp = 1'b1;
assign hresp       = 1'b0;

assert property (@(posedge clk_sys) disable iff (!rst_n)
	addr_phase |-> (hsize != size_half || !haddr[0]) &&
		(hsize != size_word || haddr[1:0] == 2'b00));

endmodule

/* hdl/ahb_to_apb.sv */
// AHB-Lite to APB bridge state machine
`timescale 1ns/10ps

module ahb_to_apb (
	input  logic             clk_sys,
	input  logic             rst_n,
	input  logic             sel,
	input  logic             hready,
	input  soc_pkg::addr_t   haddr,
	input  logic             hwrite,
	input  soc_pkg::htrans_t htrans,
	input  soc_pkg::word_t   hwdata,
	output logic             hready_resp,
	output logic             hresp,
	output soc_pkg::word_t   hrdata,
	output soc_pkg::paddr_t  paddr,
	output logic             psel,
	output logic             penable,
	output logic             pwrite,
	output soc_pkg::word_t   pwdata,
	input  soc_pkg::word_t   prdata,
	input  logic             pready,
	input  logic             pslverr
);
import soc_pkg::*;

bridge_state_t state;
logic          start;
logic          err_q;
word_t         pwdata_q;
word_t         hrdata_q;

assign start = sel && hready && (htrans == trans_nonseq || htrans == trans_seq);

// ----------------------------------------------------------------------
// Control

always_ff @(posedge clk_sys) begin
	if (!rst_n) begin
		state <= br_idle;
		err_q <= 1'b0;
	end else begin
		case (state)
			br_idle, br_done: begin
				// A new address phase may overlap the done cycle
				state <= start ? br_setup : br_idle;
				err_q <= 1'b0;
			end
			br_setup: state <= br_access;
			br_access: begin
				if (pready) begin
					state <= pslverr ? br_err_first : br_done;
					err_q <= pslverr;
				end
			end
			br_err_first: state <= br_done;
			default: state <= br_idle;
		endcase
	end
end

// ----------------------------------------------------------------------
// Datapath

always_ff @(posedge clk_sys) begin
	if (start) begin
		paddr  <= haddr[W_PADDR-1:0];
		pwrite <= hwrite;
	end
	if (state == br_setup)
		pwdata_q <= hwdata;
	if (state == br_access && pready)
		hrdata_q <= prdata;
end

// hwdata is live during setup and the copy covers the access cycles
assign pwdata      = state == br_setup ? hwdata : pwdata_q;
assign psel        = state == br_setup || state == br_access;
assign penable     = state == br_access;
assign hready_resp = state == br_idle || state == br_done;
assign hresp       = state == br_err_first || (state == br_done && err_q);
assign hrdata      = hrdata_q;

// Address and direction hold from setup through every access cycle
assert property (@(posedge clk_sys) disable iff (!rst_n)
	penable |-> $stable(paddr) && $stable(pwrite));

endmodule

/* hdl/apb_splitter.sv */
// APB slot decoder with error response on empty slots
`timescale 1ns/10ps

module apb_splitter (
	input  soc_pkg::paddr_t paddr,
	input  logic            psel,
	input  logic            penable,
	input  logic            pwrite,
	input  soc_pkg::word_t  pwdata,
	output soc_pkg::word_t  prdata,
	output logic            pready,
	output logic            pslverr,
	output logic            uart_psel,
	output soc_pkg::paddr_t uart_paddr,
	output logic            uart_penable,
	output logic            uart_pwrite,
	output soc_pkg::word_t  uart_pwdata,
	input  soc_pkg::word_t  uart_prdata,
	input  logic            uart_pready,
	input  logic            uart_pslverr
);
import soc_pkg::*;

logic [3:0] slot;
logic       uart_hit;

// 4 KiB slots
assign slot     = paddr[W_PADDR-1 -: 4];
assign uart_hit = slot == APB_SLOT_UART;

assign uart_psel    = psel && uart_hit;
assign uart_penable = penable && uart_hit;
assign uart_paddr   = paddr;
assign uart_pwrite  = pwrite;
assign uart_pwdata  = pwdata;

// Empty slots (SPI, SDRAM cfg, timer, GPIO) answer at once with an error
assign prdata  = uart_hit ? uart_prdata : '0;
assign pready  = uart_hit ? uart_pready : 1'b1;
assign pslverr = uart_hit ? uart_pslverr : 1'b1;

endmodule

/* hdl/uart_tx.sv */
// UART APB registers and 8N1 transmitter
`timescale 1ns/10ps

module uart_tx #(
	parameter logic [15:0] UART_DIV_RESET = 16'd4
) (
	input  logic            clk_sys,
	input  logic            rst_n,
	input  logic            psel,
	input  logic            penable,
	input  logic            pwrite,
	input  soc_pkg::paddr_t paddr,
	input  soc_pkg::word_t  pwdata,
	output soc_pkg::word_t  prdata,
	output logic            pready,
	output logic            pslverr,
	output logic            tx
);
import soc_pkg::*;

uart_state_t state;
logic [15:0] div_q;
logic [15:0] div_cnt;
logic [2:0]  bit_cnt;
logic [7:0]  shift_q;
logic        access;
logic        busy;
logic        bit_end;
logic        sel_csr;
logic        sel_div;
logic        sel_txdata;
logic        tx_write;

// ----------------------------------------------------------------------
// Register interface

assign access     = psel && penable;
assign sel_csr    = paddr[11:0] == UART_CSR[11:0];
assign sel_div    = paddr[11:0] == UART_DIV[11:0];
assign sel_txdata = paddr[11:0] == UART_TXDATA[11:0];
assign tx_write   = access && pwrite && sel_txdata;
assign busy       = state != uart_idle;

assign pready  = 1'b1;
assign pslverr = psel && !(sel_csr || sel_div || sel_txdata);

always_comb begin
	prdata = '0;
	if (sel_csr)
		prdata[0] = busy;
	else if (sel_div)
		prdata[15:0] = div_q;
end

always_ff @(posedge clk_sys) begin
	if (!rst_n)
		div_q <= UART_DIV_RESET;
	else if (access && pwrite && sel_div)
		div_q <= pwdata[15:0];
end

// ----------------------------------------------------------------------
// Transmitter, LSB first

assign bit_end = div_cnt == div_q - 16'd1;

always_ff @(posedge clk_sys) begin
	if (!rst_n) begin
		state   <= uart_idle;
		div_cnt <= '0;
		bit_cnt <= '0;
		tx      <= 1'b1;
	end else begin
		if (busy)
			div_cnt <= bit_end ? 16'd0 : div_cnt + 16'd1;
		case (state)
			uart_idle: begin
				div_cnt <= '0;
				bit_cnt <= '0;
				// Writes while busy fall through and are lost
				if (tx_write) begin
					state <= uart_start;
					tx    <= 1'b0;
				end
			end
			uart_start: begin
				if (bit_end) begin
					state <= uart_data;
					tx    <= shift_q[0];
				end
			end
			uart_data: begin
				if (bit_end) begin
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7) begin
						state <= uart_stop;
						tx    <= 1'b1;
					end else begin
						tx <= shift_q[1];
					end
				end
			end
			default: begin
				if (bit_end)
					state <= uart_idle;
			end
		endcase
	end
end

always_ff @(posedge clk_sys) begin
	if (tx_write && !busy)
		shift_q <= pwdata[7:0];
	else if (state == uart_data && bit_end)
		shift_q <= shift_q >> 1;
end

// Software must never program a zero divider
assert property (@(posedge clk_sys) disable iff (!rst_n)
	access && pwrite && sel_div |-> pwdata[15:0] != 16'd0);

endmodule

/* hdl/soc_top.sv */
// Fabric top level: AHB decode, TCM, APB bridge, APB decode and UART
`timescale 1ns/10ps

module soc_top #(
	parameter int          SRAM_DEPTH     = 1024,
	parameter logic [15:0] UART_DIV_RESET = 16'd4
) (
	input  logic             clk_sys,
	input  logic             rst_n,

	input  soc_pkg::addr_t   haddr,
	input  logic             hwrite,
	input  soc_pkg::htrans_t htrans,
	input  soc_pkg::hsize_t  hsize,
	input  soc_pkg::word_t   hwdata,
	output soc_pkg::word_t   hrdata,
	output logic             hready,
	output logic             hresp,

	output logic             uart_tx
);
import soc_pkg::*;

// ----------------------------------------------------------------------
// AHB layer

logic   sram_sel;
logic   sram_hready_resp;
logic   sram_hresp;
word_t  sram_hrdata;

logic   peri_sel;
logic   peri_hready_resp;
logic   peri_hresp;
word_t  peri_hrdata;

ahb_splitter u_split (
	.clk_sys          (clk_sys),
	.rst_n            (rst_n),
	.haddr            (haddr),
	.htrans           (htrans),
	.hready           (hready),
	.hresp            (hresp),
	.hrdata           (hrdata),
	.sram_sel         (sram_sel),
	.peri_sel         (peri_sel),
	.sram_hready_resp (sram_hready_resp),
	.sram_hresp       (sram_hresp),
	.sram_hrdata      (sram_hrdata),
	.peri_hready_resp (peri_hready_resp),
	.peri_hresp       (peri_hresp),
	.peri_hrdata      (peri_hrdata)
);

ahb_sram #(
	.SRAM_DEPTH (SRAM_DEPTH)
) u_tcm (
	.clk_sys     (clk_sys),
	.rst_n       (rst_n),
	.sel         (sram_sel),
	.hready      (hready),
	.haddr       (haddr),
	.hwrite      (hwrite),
	.htrans      (htrans),
	.hsize       (hsize),
	.hwdata      (hwdata),
	.hready_resp (sram_hready_resp),
	.hresp       (sram_hresp),
	.hrdata      (sram_hrdata)
);

// ----------------------------------------------------------------------
// APB layer

paddr_t peri_paddr;
logic   peri_psel;
logic   peri_penable;
logic   peri_pwrite;
word_t  peri_pwdata;
word_t  peri_prdata;
logic   peri_pready;
logic   peri_pslverr;

ahb_to_apb u_bridge (
	.clk_sys     (clk_sys),
	.rst_n       (rst_n),
	.sel         (peri_sel),
	.hready      (hready),
	.haddr       (haddr),
	.hwrite      (hwrite),
	.htrans      (htrans),
	.hwdata      (hwdata),
	.hready_resp (peri_hready_resp),
	.hresp       (peri_hresp),
	.hrdata      (peri_hrdata),
	.paddr       (peri_paddr),
	.psel        (peri_psel),
	.penable     (peri_penable),
	.pwrite      (peri_pwrite),
	.pwdata      (peri_pwdata),
	.prdata      (peri_prdata),
	.pready      (peri_pready),
	.pslverr     (peri_pslverr)
);

paddr_t uart_paddr;
logic   uart_psel;
logic   uart_penable;
logic   uart_pwrite;
word_t  uart_pwdata;
word_t  uart_prdata;
logic   uart_pready;
logic   uart_pslverr;

apb_splitter u_apb_split (
	.paddr        (peri_paddr),
	.psel         (peri_psel),
	.penable      (peri_penable),
	.pwrite       (peri_pwrite),
	.pwdata       (peri_pwdata),
	.prdata       (peri_prdata),
	.pready       (peri_pready),
	.pslverr      (peri_pslverr),
	.uart_psel    (uart_psel),
	.uart_paddr   (uart_paddr),
	.uart_penable (uart_penable),
	.uart_pwrite  (uart_pwrite),
	.uart_pwdata  (uart_pwdata),
	.uart_prdata  (uart_prdata),
	.uart_pready  (uart_pready),
	.uart_pslverr (uart_pslverr)
);

uart_tx #(
	.UART_DIV_RESET (UART_DIV_RESET)
) u_uart (
	.clk_sys (clk_sys),
	.rst_n   (rst_n),
	.psel    (uart_psel),
	.penable (uart_penable),
	.pwrite  (uart_pwrite),
	.paddr   (uart_paddr),
	.pwdata  (uart_pwdata),
	.prdata  (uart_prdata),
	.pready  (uart_pready),
	.pslverr (uart_pslverr),
	.tx      (uart_tx)
);

endmodule

/* tests/tb_clock.sv */
// Testbench clock and synchronous reset generator
`timescale 1ns/10ps

module tb_clock (
	output logic clk_sys,
	output logic rst_n
);

// 4 ns period
initial begin
	clk_sys = 1'b0;
	forever #2 clk_sys = ~clk_sys;
end

// Reset held low for 10 cycles, released just after an edge
initial begin
	rst_n = 1'b0;
	repeat (10) @(posedge clk_sys);
	#1;
	rst_n = 1'b1;
end

endmodule

/* tests/tb_top.sv */
// Testbench top: DUT, AHB bus tasks, compare tasks, directed tests and final report
`timescale 1ns/10ps

module tb_top;
import soc_pkg::*;

localparam int          SRAM_DEPTH     = 1024;
localparam logic [15:0] UART_DIV_RESET = 16'd4;
localparam int          UART_DIV_TEST  = 3;
localparam int          TIMEOUT        = 1000;
localparam int          PIPE_LEN       = 32;

logic    clk_sys;
logic    rst_n;
addr_t   haddr;
logic    hwrite;
htrans_t htrans;
hsize_t  hsize;
word_t   hwdata;
word_t   hrdata;
logic    hready;
logic    hresp;
logic    uart_tx;

int      errors;
int      timeouts;
bit      hung;
word_t   model [SRAM_DEPTH];

tb_clock clk_gen (.clk_sys(clk_sys), .rst_n(rst_n));

soc_top #(
	.SRAM_DEPTH     (SRAM_DEPTH),
	.UART_DIV_RESET (UART_DIV_RESET)
) dut0 (
	.clk_sys (clk_sys),
	.rst_n   (rst_n),
	.haddr   (haddr),
	.hwrite  (hwrite),
	.htrans  (htrans),
	.hsize   (hsize),
	.hwdata  (hwdata),
	.hrdata  (hrdata),
	.hready  (hready),
	.hresp   (hresp),
	.uart_tx (uart_tx)
);

// ----------------------------------------------------------------------
// Compare tasks and timing helpers

task automatic check_word(input string name, input word_t actual, input word_t expected);
	if (actual !== expected) begin
		errors++;
		$display("Error: %s = 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
	end
endtask

task automatic check_resp(input string name, input bit actual, input bit expected);
	if (actual != expected) begin
		errors++;
		$display("Error: %s = 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
	end
endtask

task automatic report_timeout(input string what);
	timeouts++;
	hung = 1'b1;
	$display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
endtask

// Next rising edge plus the drive delay
task automatic step();
	@(posedge clk_sys);
	#1;
endtask

// Fixed number of cycles, staying at the sample point
task automatic skip_cycles(input int n);
	repeat (n) @(posedge clk_sys);
	#3;
endtask

// Ends at the sample point of the cycle where hready is high
task automatic wait_ready(input string what);
	int n;
	n = 0;
	#2;
	while (!hready && !hung && n < TIMEOUT) begin
		@(posedge clk_sys);
		#3;
		n++;
	end
	if (n >= TIMEOUT)
		report_timeout(what);
endtask

function automatic addr_t word_addr(input int idx);
	return TCM_BASE | addr_t'(idx << 2);
endfunction

function automatic addr_t uart_addr(input paddr_t off);
	return PERI_BASE | {16'h0000, off};
endfunction

// ----------------------------------------------------------------------
// AHB-Lite single transfers

task automatic ahb_transfer(input addr_t addr, input logic write, input hsize_t size,
	input word_t wdata, output word_t rdata, output logic resp);
	haddr  = addr;
	hwrite = write;
	hsize  = size;
	htrans = trans_nonseq;
	wait_ready("address phase");
	step();
	htrans = trans_idle;
	hwdata = wdata;
	wait_ready("end of data phase");
	rdata = hrdata;
	resp  = hresp;
	step();
endtask

task automatic write_ok(input addr_t addr, input hsize_t size, input word_t data);
	word_t rdata;
	logic  resp;
	ahb_transfer(addr, 1'b1, size, data, rdata, resp);
	check_resp("hresp", resp, 1'b0);
endtask

task automatic read_check(input addr_t addr, input word_t expected);
	word_t rdata;
	logic  resp;
	ahb_transfer(addr, 1'b0, size_word, '0, rdata, resp);
	check_resp("hresp", resp, 1'b0);
	check_word("hrdata", rdata, expected);
endtask

// ----------------------------------------------------------------------
// Directed tests

task automatic test_reset_state();
	#2;
	check_resp("hready", hready, 1'b1);
	check_resp("hresp", hresp, 1'b0);
	check_resp("uart_tx", uart_tx, 1'b1);
	step();
	read_check(uart_addr(UART_CSR), 32'h0);
	read_check(uart_addr(UART_DIV), {16'h0000, UART_DIV_RESET});
endtask

task automatic test_byte_lanes();
	write_ok(32'h0000_0100, size_word, 32'h1122_3344);
	write_ok(32'h0000_0101, size_byte, {4{8'hab}});
	write_ok(32'h0000_0102, size_half, {2{16'hcdef}});
	// Byte in lane 1, half-word in lanes 3:2
	read_check(32'h0000_0100, 32'hcdef_ab44);
	read_check(32'h0000_0100 + addr_t'(SRAM_DEPTH * 4), 32'hcdef_ab44);
endtask

task automatic test_pipelined_sram();
	int    idx [PIPE_LEN];
	word_t wdata [PIPE_LEN];
	// Keep clear of the lane test word at index 64
	for (int i = 0; i < PIPE_LEN; i++) begin
		idx[i]        = 128 + int'($urandom % (SRAM_DEPTH - 128));
		wdata[i]      = $urandom;
		model[idx[i]] = wdata[i];
	end
	// Writes then reads with no gap, one slot per cycle
	for (int s = 0; s <= 2 * PIPE_LEN; s++) begin
		if (s < 2 * PIPE_LEN) begin
			htrans = trans_nonseq;
			hsize  = size_word;
			hwrite = s < PIPE_LEN;
			haddr  = word_addr(idx[s % PIPE_LEN]);
		end else begin
			htrans = trans_idle;
		end
		if (s >= 1 && s <= PIPE_LEN)
			hwdata = wdata[s - 1];
		wait_ready("pipelined SRAM transfer");
		if (s > PIPE_LEN)
			check_word("hrdata", hrdata, model[idx[s - 1 - PIPE_LEN]]);
		step();
	end
endtask

task automatic test_error_responses();
	word_t rdata;
	logic  resp;
	ahb_transfer(32'h0800_0000, 1'b0, size_word, '0, rdata, resp);
	check_resp("hresp", resp, 1'b1);
	ahb_transfer(32'h0c00_1000, 1'b1, size_word, 32'h5a5a_5a5a, rdata, resp);
	check_resp("hresp", resp, 1'b1);
	ahb_transfer(uart_addr(16'h000c), 1'b0, size_word, '0, rdata, resp);
	check_resp("hresp", resp, 1'b1);
	read_check(32'h0000_0100, 32'hcdef_ab44);
endtask

// Samples the serial line at the centre of every bit
task automatic capture_frame(input int div, input logic [7:0] expected);
	int n;
	n = 0;
	#2;
	while (uart_tx !== 1'b0 && !hung && n < TIMEOUT) begin
		@(posedge clk_sys);
		#3;
		n++;
	end
	if (n >= TIMEOUT) begin
		report_timeout("UART start bit");
	end else if (!hung) begin
		skip_cycles(div / 2);
		check_resp("uart_tx start bit", uart_tx, 1'b0);
		for (int b = 0; b < 8; b++) begin
			skip_cycles(div);
			check_resp($sformatf("uart_tx bit %0d", b), uart_tx, expected[b]);
		end
		skip_cycles(div);
		check_resp("uart_tx stop bit", uart_tx, 1'b1);
		// Past the end of the stop bit
		skip_cycles(div);
	end
endtask

task automatic test_uart_tx();
	logic [7:0] tx_byte;
	tx_byte = 8'($urandom);
	write_ok(uart_addr(UART_DIV), size_word, word_t'(UART_DIV_TEST));
	read_check(uart_addr(UART_DIV), word_t'(UART_DIV_TEST));
	fork
		begin
			write_ok(uart_addr(UART_TXDATA), size_word, {24'h0, tx_byte});
			read_check(uart_addr(UART_CSR), 32'h1);
		end
		capture_frame(UART_DIV_TEST, tx_byte);
	join
	step();
	read_check(uart_addr(UART_CSR), 32'h0);
endtask

// ----------------------------------------------------------------------
// Main sequence

initial begin
	int n;
	haddr    = '0;
	hwrite   = 1'b0;
	htrans   = trans_idle;
	hsize    = size_word;
	hwdata   = '0;
	errors   = 0;
	timeouts = 0;
	hung     = 1'b0;
	n        = 0;
	void'($urandom(32'hac214eda));

	while (rst_n !== 1'b1 && n < TIMEOUT) begin
		@(posedge clk_sys);
		n++;
	end
	if (n >= TIMEOUT)
		report_timeout("reset release");
	step();

	test_reset_state();
	test_byte_lanes();
	test_pipelined_sram();
	test_error_responses();
	test_uart_tx();

	$display("Finished with %0d errors and %0d timeouts", errors, timeouts);
	if (errors == 0 && timeouts == 0)
		$display("Test passed");
	else
		$display("Test failed");
	$finish;
end

endmodule

/* list.f */
hdl/soc_pkg.sv
hdl/ahb_splitter.sv
hdl/ahb_sram.sv
hdl/ahb_to_apb.sv
hdl/apb_splitter.sv
hdl/uart_tx.sv
hdl/soc_top.sv
tests/tb_clock.sv
tests/tb_top.sv

/* run.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module tb_top -f list.f -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
